// File: all.f
+incdir+source
source/mem_stage_pkg.sv
source/lsu.sv
source/dmem_bank.sv
source/load_aligner.sv
source/credit_tx.sv
source/mem_stage.sv
verification/mem_stage_tb.sv

// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing -Wno-fatal
TOP       = mem_stage_tb
FILE_LIST = all.f

.PHONY: simulate clean

simulate:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: verification/mem_stage_golden.txt
# num decode rs1 rs2 offset rd pc_plus4 icache_miss kind exp0 exp1 exp2 exp3 exp4
# kind 1 load (exp0 data), 2 remote (addr data mask load_info {wnr,amo,amo_type}), 3 resv, 4 stall, 5 hold credits
1  200 00001000 89abcdef 00000100 00 00000000 0 0 00000000 00000000 0 00 0
2  280 00001000 00007e01 00000102 00 00000000 0 0 00000000 00000000 0 00 0
3  300 00001000 000000f5 00000101 00 00000000 0 0 00000000 00000000 0 00 0
4  400 00001000 00000000 00000100 01 00000000 0 1 7e01f5ef 00000000 0 00 0
5  500 00001000 00000000 00000100 02 00000000 0 1 ffffffef 00000000 0 00 0
6  540 00001000 00000000 00000100 03 00000000 0 1 000000ef 00000000 0 00 0
7  500 00001000 00000000 00000101 04 00000000 0 1 fffffff5 00000000 0 00 0
8  540 00001000 00000000 00000101 05 00000000 0 1 000000f5 00000000 0 00 0
9  500 00001000 00000000 00000102 06 00000000 0 1 00000001 00000000 0 00 0
10 540 00001000 00000000 00000102 07 00000000 0 1 00000001 00000000 0 00 0
11 500 00001000 00000000 00000103 08 00000000 0 1 0000007e 00000000 0 00 0
12 540 00001000 00000000 00000103 09 00000000 0 1 0000007e 00000000 0 00 0
13 480 00001000 00000000 00000100 0a 00000000 0 1 fffff5ef 00000000 0 00 0
14 4c0 00001000 00000000 00000100 0b 00000000 0 1 0000f5ef 00000000 0 00 0
15 480 00001000 00000000 00000102 0c 00000000 0 1 00007e01 00000000 0 00 0
16 4c0 00001000 00000000 00000102 0d 00000000 0 1 00007e01 00000000 0 00 0
17 280 20000000 0000beef 00000012 00 00000000 0 2 20000012 beefbeef c 06 8
18 500 20000000 00000000 00000023 07 00000000 0 2 20000023 00000000 8 0b 0
19 4c0 20000000 00000000 00000032 0e 00000000 0 2 20000032 00000000 c 16 0
20 021 30000000 00000005 00000004 0f 00000000 0 2 30000004 00000005 f 00 5
21 000 00000000 00000000 00000000 00 00000104 1 2 80000100 00000000 f 20 0
22 500 00001000 00000000 00000001 03 00002008 1 2 80002004 00000000 2 20 0
23 000 00000000 00000000 00000000 00 00000000 0 5 00000000 00000000 0 00 0
24 400 40000000 00000000 00000000 01 00000000 0 2 40000000 00000000 f 00 0
25 400 40000000 00000000 00000004 02 00000000 0 2 40000004 00000000 f 00 0
26 400 40000000 00000000 00000008 03 00000000 0 2 40000008 00000000 f 00 0
27 400 40000000 00000000 0000000c 04 00000000 0 2 4000000c 00000000 f 00 0
28 400 40000000 00000000 00000010 05 00000000 0 4 40000010 00000000 f 00 0
29 400 40000000 00000000 00000014 06 00000000 0 2 40000014 00000000 f 00 0
30 410 00001000 00000000 00000200 0a 00000000 0 3 00000001 00000000 0 00 0
31 200 00001000 00000011 00000204 00 00000000 0 3 00000001 00000000 0 00 0
32 300 00001000 00000022 00000203 00 00000000 0 3 00000000 00000000 0 00 0

// File: verification/mem_stage_tb.sv
// memory stage testbench
// replays the golden operation list through the stage and checks
// local load returns, network requests, credit stalls and the reservation

`timescale 1ns/10ps

`include "mem_stage_defs.svh"

module mem_stage_tb;

  localparam int kind_load   = 1;
  localparam int kind_remote = 2;
  localparam int kind_resv   = 3;
  localparam int kind_stall  = 4;
  localparam int kind_hold   = 5;

  logic                               clk_i;
  logic                               reset_i;
  mem_stage_pkg::decode_s             exe_decode_i;
  logic [`DATA_WIDTH-1:0]             exe_rs1_i;
  logic [`DATA_WIDTH-1:0]             exe_rs2_i;
  logic [`REG_ADDR_WIDTH-1:0]         exe_rd_i;
  logic [`DATA_WIDTH-1:0]             mem_offset_i;
  logic [`DATA_WIDTH-1:0]             pc_plus4_i;
  logic                               icache_miss_i;
  logic                               remote_credit_i;
  logic                               stall_o;
  mem_stage_pkg::remote_req_s         remote_req_o;
  logic                               remote_v_o;
  logic                               load_v_o;
  logic [`REG_ADDR_WIDTH-1:0]         load_rd_o;
  logic [`DATA_WIDTH-1:0]             load_data_o;
  logic                               reservation_v_o;

  mem_stage_pkg::remote_req_s expected_q [$];
  string                      lines [$];
  bit                         withhold = 1'b0;
  bit                         limit_set = 1'b0;
  int                         received = 0;
  int                         returned = 0;
  int                         errors = 0;
  int                         pass_cnt = 0;
  int                         fail_cnt = 0;
  int                         cycles = 0;
  int                         cycle_limit = 0;

  mem_stage u_mem_stage (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .exe_decode_i    (exe_decode_i),
    .exe_rs1_i       (exe_rs1_i),
    .exe_rs2_i       (exe_rs2_i),
    .exe_rd_i        (exe_rd_i),
    .mem_offset_i    (mem_offset_i),
    .pc_plus4_i      (pc_plus4_i),
    .icache_miss_i   (icache_miss_i),
    .remote_credit_i (remote_credit_i),
    .stall_o         (stall_o),
    .remote_req_o    (remote_req_o),
    .remote_v_o      (remote_v_o),
    .load_v_o        (load_v_o),
    .load_rd_o       (load_rd_o),
    .load_data_o     (load_data_o),
    .reservation_v_o (reservation_v_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic drive_idle();
    exe_decode_i  = '0;
    exe_rs1_i     = '0;
    exe_rs2_i     = '0;
    exe_rd_i      = '0;
    mem_offset_i  = '0;
    pc_plus4_i    = '0;
    icache_miss_i = 1'b0;
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("Mismatch %s expected 0x%0h got 0x%0h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_remote(input mem_stage_pkg::remote_req_s exp,
                              input mem_stage_pkg::remote_req_s got);
    compare_field("remote_req_o.write_not_read", 32'(exp.write_not_read),
                  32'(got.write_not_read));
    compare_field("remote_req_o.is_amo_op", 32'(exp.is_amo_op), 32'(got.is_amo_op));
    compare_field("remote_req_o.amo_type", 32'(exp.amo_type), 32'(got.amo_type));
    compare_field("remote_req_o.mask", 32'(exp.mask), 32'(got.mask));
    compare_field("remote_req_o.load_info", 32'(exp.load_info), 32'(got.load_info));
    compare_field("remote_req_o.reg_id", 32'(exp.reg_id), 32'(got.reg_id));
    compare_field("remote_req_o.data", exp.data, got.data);
    compare_field("remote_req_o.addr", exp.addr, got.addr);
  endtask

  task automatic check_load(input logic [`REG_ADDR_WIDTH-1:0] exp_rd,
                            input logic [`DATA_WIDTH-1:0] exp_data);
    compare_field("load_v_o", 32'h1, 32'(load_v_o));
    compare_field("load_rd_o", 32'(exp_rd), 32'(load_rd_o));
    compare_field("load_data_o", exp_data, load_data_o);
  endtask

  task automatic check_reservation(input logic exp_v);
    compare_field("reservation_v_o", 32'(exp_v), 32'(reservation_v_o));
  endtask

  // keep the operation lines and skip the # comment lines
  task automatic read_golden();
    int    fd;
    string line;
    fd = $fopen("verification/mem_stage_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file verification/mem_stage_golden.txt");
      errors++;
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_line(input string line);
    int                         num;
    int                         kind;
    int                         cnt;
    int                         errs_before;
    bit                         stalled;
    logic [31:0]                dec_h, rs1, rs2, off, rd_h, pc4, miss_h;
    logic [31:0]                e0, e1, e2, e3, e4;
    mem_stage_pkg::remote_req_s exp_req;
    cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %d %h %h %h %h %h", num, dec_h, rs1,
                  rs2, off, rd_h, pc4, miss_h, kind, e0, e1, e2, e3, e4);
    errs_before = errors;
    stalled = 1'b0;
    if (cnt != 14) begin
      $display("golden line has %0d fields instead of 14: %s", cnt, line);
      errors++;
    end else if (kind == kind_hold) begin
      // let every credit come home, then stop returning them
      while (received != returned) @(negedge clk_i);
      withhold = 1'b1;
    end else begin
      @(negedge clk_i);
      exe_decode_i  = mem_stage_pkg::decode_s'(dec_h[10:0]);
      exe_rs1_i     = rs1;
      exe_rs2_i     = rs2;
      mem_offset_i  = off;
      exe_rd_i      = rd_h[4:0];
      pc_plus4_i    = pc4;
      icache_miss_i = miss_h[0];
      #2;
      while (stall_o) begin
        stalled = 1'b1;
        if (kind == kind_stall) withhold = 1'b0;
        @(negedge clk_i);
        #2;
      end
      if (kind == kind_remote || kind == kind_stall) begin
        exp_req.write_not_read = e4[3];
        exp_req.is_amo_op      = e4[2];
        exp_req.amo_type       = mem_stage_pkg::amo_type_e'(e4[1:0]);
        exp_req.mask           = e2[3:0];
        exp_req.load_info      = mem_stage_pkg::load_info_s'(e3[6:0]);
        exp_req.reg_id         = rd_h[4:0];
        exp_req.data           = e1;
        exp_req.addr           = e0;
        expected_q.push_back(exp_req);
      end
      @(negedge clk_i);
      drive_idle();
      // the link monitor has seen this edge by now
      #1;
      if (expected_q.size() != 0) begin
        $display("remote request did not leave one cycle after acceptance");
        void'(expected_q.pop_front());
        errors++;
      end
      if (kind == kind_load) check_load(rd_h[4:0], e0);
      if (kind == kind_resv) check_reservation(e0[0]);
      if (kind == kind_remote || kind == kind_stall) begin
        compare_field("load_v_o", 32'h0, 32'(load_v_o));
      end
      if (kind == kind_stall && !stalled) begin
        $display("stall_o never rose although no credit was left");
        errors++;
      end
    end
    if (errors == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("test %0d %s", num, (errors == errs_before) ? "ok" : "failed");
  endtask

  // each request seen on the link is matched against the oldest expected one
  always @(negedge clk_i) begin
    if (reset_i && remote_v_o) begin
      received++;
      if (expected_q.size() == 0) begin
        $display("remote request sent with no operation asking for it");
        errors++;
      end else begin
        check_remote(expected_q.pop_front(), remote_req_o);
      end
    end
  end

  // network side handing back one credit per received request
  initial begin
    int gap;
    void'($urandom(32'h9726));
    remote_credit_i = 1'b0;
    forever begin
      @(negedge clk_i);
      remote_credit_i = 1'b0;
      if (!withhold && received > returned) begin
        gap = $urandom_range(3, 0);
        repeat (gap) @(negedge clk_i);
        if (!withhold) begin
          remote_credit_i = 1'b1;
          returned++;
        end
      end
    end
  end

  initial begin
    wait (limit_set);
    while (cycles <= cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout, the run went past %0d cycles", cycle_limit);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int errs_before;
    reset_i = 1'b0;
    drive_idle();
    read_golden();
    cycle_limit = 20 * lines.size() + 100;
    limit_set = 1'b1;
    repeat (4) @(negedge clk_i);
    reset_i = 1'b1;
    errs_before = errors;
    compare_field("remote_v_o", 32'h0, 32'(remote_v_o));
    compare_field("load_v_o", 32'h0, 32'(load_v_o));
    compare_field("stall_o", 32'h0, 32'(stall_o));
    check_reservation(1'b0);
    if (errors == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("test 0 reset state %s", (errors == errs_before) ? "ok" : "failed");
    foreach (lines[i]) run_line(lines[i]);
    if (expected_q.size() != 0) begin
      $display("%0d remote requests never arrived", expected_q.size());
      errors++;
      fail_cnt++;
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: source/mem_stage.sv
// memory stage top
// load store unit, local data memory, load return path and the
// credit based network transmit port

`timescale 1ns/10ps

`include "mem_stage_defs.svh"

module mem_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  mem_stage_pkg::decode_s      exe_decode_i,
  input  logic [`DATA_WIDTH-1:0]      exe_rs1_i,
  input  logic [`DATA_WIDTH-1:0]      exe_rs2_i,
  input  logic [`REG_ADDR_WIDTH-1:0]  exe_rd_i,
  input  logic [`DATA_WIDTH-1:0]      mem_offset_i,
  input  logic [`DATA_WIDTH-1:0]      pc_plus4_i,
  input  logic                        icache_miss_i,
  input  logic                        remote_credit_i,
  output logic                        stall_o,
  output mem_stage_pkg::remote_req_s  remote_req_o,
  output logic                        remote_v_o,
  output logic                        load_v_o,
  output logic [`REG_ADDR_WIDTH-1:0]  load_rd_o,
  output logic [`DATA_WIDTH-1:0]      load_data_o,
  output logic                        reservation_v_o
);

  logic                        dmem_v;
  logic                        dmem_w;
  logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr;
  logic [`DATA_WIDTH-1:0]      dmem_data;
  logic [`DATA_MASK_WIDTH-1:0] dmem_mask;
  logic [`DATA_WIDTH-1:0]      dmem_rdata;
  logic                        reserve;
  logic                        local_load_v;
  mem_stage_pkg::load_info_s   load_info;
  mem_stage_pkg::remote_req_s  remote_req;
  logic                        remote_v;

  lsu u_lsu (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .exe_decode_i   (exe_decode_i),
    .exe_rs1_i      (exe_rs1_i),
    .exe_rs2_i      (exe_rs2_i),
    .mem_offset_i   (mem_offset_i),
    .pc_plus4_i     (pc_plus4_i),
    .exe_rd_i       (exe_rd_i),
    .icache_miss_i  (icache_miss_i),
    .dmem_v_o       (dmem_v),
    .dmem_w_o       (dmem_w),
    .dmem_addr_o    (dmem_addr),
    .dmem_data_o    (dmem_data),
    .dmem_mask_o    (dmem_mask),
    .reserve_o      (reserve),
    .local_load_v_o (local_load_v),
    .load_info_o    (load_info),
    .remote_req_o   (remote_req),
    .remote_v_o     (remote_v)
  );

  dmem_bank u_dmem_bank (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .v_i             (dmem_v),
    .w_i             (dmem_w),
    .addr_i          (dmem_addr),
    .data_i          (dmem_data),
    .mask_i          (dmem_mask),
    .reserve_i       (reserve),
    .data_o          (dmem_rdata),
    .reservation_v_o (reservation_v_o)
  );

  load_aligner u_load_aligner (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_v_i    (local_load_v),
    .load_info_i (load_info),
    .rd_i        (exe_rd_i),
    .rdata_i     (dmem_rdata),
    .load_v_o    (load_v_o),
    .load_rd_o   (load_rd_o),
    .load_data_o (load_data_o)
  );

  credit_tx #(
    .payload_t (mem_stage_pkg::remote_req_s)
  ) u_credit_tx (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (remote_v),
    .data_i   (remote_req),
    .credit_i (remote_credit_i),
    .stall_o  (stall_o),
    .v_o      (remote_v_o),
    .data_o   (remote_req_o)
  );

endmodule

// File: source/credit_tx.sv
// credit based transmit port
// registers accepted payloads onto the link and tracks credits
// returned by the receiver

`timescale 1ns/10ps

`include "mem_stage_defs.svh"

module credit_tx #(
  parameter type payload_t = mem_stage_pkg::remote_req_s
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     v_i,
  input  payload_t data_i,
  input  logic     credit_i,
  output logic     stall_o,
  output logic     v_o,
  output payload_t data_o
);

  localparam int credit_width = $clog2(`TX_CREDITS + 1);
  localparam logic [credit_width-1:0] credits_max = credit_width'(`TX_CREDITS);

  logic [credit_width-1:0] credits_q;
  logic                    has_credit;
  logic                    accept;
  logic                    v_q;
  payload_t                data_q;

  assign has_credit = (credits_q != '0);
  assign accept     = v_i & has_credit;

  // sender must hold the request until a credit shows up
  assign stall_o = v_i & ~has_credit;

  // one credit out per accept, one back per credit_i cycle
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      credits_q <= credits_max;
    end else begin
      credits_q <= credits_q + credit_width'(credit_i) - credit_width'(accept);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      v_q <= 1'b0;
    end else begin
      v_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= data_i;
    end
  end

  assign v_o    = v_q;
  assign data_o = data_q;

  credits_bounded: assert property (
    @(posedge clk_i) disable iff (!reset_i)
    credits_q <= credits_max
  ) else $error("credit_tx: credit count %0d above limit", credits_q);

  // receiver returned a credit nobody was holding
  no_extra_credit: assert property (
    @(posedge clk_i) disable iff (!reset_i)
    !(credit_i && credits_q == credits_max)
  ) else $error("credit_tx: credit returned while counter is full");

endmodule

// File: source/load_aligner.sv
// local load return path
// holds the info of a local load for one cycle, then picks the
// byte or half out of the read word and extends it

`timescale 1ns/10ps

`include "mem_stage_defs.svh"

module load_aligner (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        load_v_i,
  input  mem_stage_pkg::load_info_s   load_info_i,
  input  logic [`REG_ADDR_WIDTH-1:0]  rd_i,
  input  logic [`DATA_WIDTH-1:0]      rdata_i,
  output logic                        load_v_o,
  output logic [`REG_ADDR_WIDTH-1:0]  load_rd_o,
  output logic [`DATA_WIDTH-1:0]      load_data_o
);

  logic                       load_v_q;
  mem_stage_pkg::load_info_s  info_q;
  logic [`REG_ADDR_WIDTH-1:0] rd_q;
  logic [7:0]                 byte_sel;
  logic [15:0]                half_sel;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      load_v_q <= 1'b0;
    end else begin
      load_v_q <= load_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_v_i) begin
      info_q <= load_info_i;
      rd_q   <= rd_i;
    end
  end

  assign byte_sel = rdata_i[8*info_q.part_sel +: 8];
  assign half_sel = info_q.part_sel[1] ? rdata_i[31:16] : rdata_i[15:0];

  // sign bit is forced low for unsigned loads
  always_comb begin
    if (info_q.is_byte_op) begin
      load_data_o = {{24{~info_q.is_unsigned_op & byte_sel[7]}}, byte_sel};
    end else if (info_q.is_hex_op) begin
      load_data_o = {{16{~info_q.is_unsigned_op & half_sel[15]}}, half_sel};
    end else begin
      load_data_o = rdata_i;
    end
  end

  assign load_v_o  = load_v_q;
  assign load_rd_o = rd_q;

endmodule

// File: source/dmem_bank.sv
// local data memory bank
// byte-enabled writes, registered read and a single load reservation

`timescale 1ns/10ps

`include "mem_stage_defs.svh"

module dmem_bank (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         v_i,
  input  logic                         w_i,
  input  logic [`DMEM_ADDR_WIDTH-1:0]  addr_i,
  input  logic [`DATA_WIDTH-1:0]       data_i,
  input  logic [`DATA_MASK_WIDTH-1:0]  mask_i,
  input  logic                         reserve_i,
  output logic [`DATA_WIDTH-1:0]       data_o,
  output logic                         reservation_v_o
);

  localparam int depth = 1 << `DMEM_ADDR_WIDTH;

  logic [`DATA_WIDTH-1:0]      mem [depth];
  logic [`DATA_WIDTH-1:0]      rdata_q;
  logic                        resv_v_q;
  logic [`DMEM_ADDR_WIDTH-1:0] resv_addr_q;
  logic                        wr_en;

  assign wr_en = v_i & w_i;

  // write lands at the edge, so a load one cycle later sees it
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < `DATA_MASK_WIDTH; b++) begin
        if (mask_i[b]) begin
          mem[addr_i][8*b +: 8] <= data_i[8*b +: 8];
        end
      end
    end else if (v_i) begin
      rdata_q <= mem[addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      resv_v_q <= 1'b0;
    end else if (reserve_i) begin
      resv_v_q <= 1'b1;
    end else if (wr_en && |mask_i && (addr_i == resv_addr_q)) begin
      // any byte written to the reserved word breaks it
      resv_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reserve_i) begin
      resv_addr_q <= addr_i;
    end
  end

  assign data_o          = rdata_q;
  assign reservation_v_o = resv_v_q;

  no_write_with_reserve: assert property (
    @(posedge clk_i) disable iff (!reset_i)
    !(wr_en && reserve_i)
  ) else $error("dmem_bank: write and reserve in the same cycle");

endmodule

// File: source/lsu.sv
// load store unit
// forms the address, store data and byte mask, then routes the
// operation to local data memory or to the network

`timescale 1ns/10ps

`include "mem_stage_defs.svh"

module lsu (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  mem_stage_pkg::decode_s       exe_decode_i,
  input  logic [`DATA_WIDTH-1:0]       exe_rs1_i,
  input  logic [`DATA_WIDTH-1:0]       exe_rs2_i,
  input  logic [`DATA_WIDTH-1:0]       mem_offset_i,
  input  logic [`DATA_WIDTH-1:0]       pc_plus4_i,
  input  logic [`REG_ADDR_WIDTH-1:0]   exe_rd_i,
  input  logic                         icache_miss_i,
  output logic                         dmem_v_o,
  output logic                         dmem_w_o,
  output logic [`DMEM_ADDR_WIDTH-1:0]  dmem_addr_o,
  output logic [`DATA_WIDTH-1:0]       dmem_data_o,
  output logic [`DATA_MASK_WIDTH-1:0]  dmem_mask_o,
  output logic                         reserve_o,
  output logic                         local_load_v_o,
  output mem_stage_pkg::load_info_s    load_info_o,
  output mem_stage_pkg::remote_req_s   remote_req_o,
  output logic                         remote_v_o
);

  logic [`DATA_WIDTH-1:0]      mem_addr;
  logic [`DATA_WIDTH-1:0]      miss_addr;
  logic [`DATA_WIDTH-1:0]      store_data;
  logic [`DATA_MASK_WIDTH-1:0] store_mask;
  logic                        is_local;
  logic                        local_op;
  mem_stage_pkg::load_info_s   op_info;
  mem_stage_pkg::load_info_s   fetch_info;

  assign mem_addr  = exe_rs1_i + mem_offset_i;
  assign miss_addr = (pc_plus4_i - `DATA_WIDTH'(4)) | `DRAM_NPA_PREFIX;

  // byte and half stores are replicated across the word
  always_comb begin
    if (exe_decode_i.is_byte_op) begin
      store_data = {4{exe_rs2_i[7:0]}};
      store_mask = 4'b0001 << mem_addr[1:0];
    end else if (exe_decode_i.is_hex_op) begin
      store_data = {2{exe_rs2_i[15:0]}};
      store_mask = mem_addr[1] ? 4'b1100 : 4'b0011;
    end else begin
      // word and amo stores
      store_data = exe_rs2_i;
      store_mask = 4'b1111;
    end
  end

  assign is_local = ((mem_addr & `DMEM_MASK) == `DMEM_BASE);

  // nothing goes local while an icache miss owns the cycle
  assign local_op = is_local & ~icache_miss_i &
                    (exe_decode_i.is_load_op | exe_decode_i.is_store_op |
                     exe_decode_i.is_lr_op | exe_decode_i.is_lr_aq_op);

  assign dmem_v_o    = local_op;
  assign dmem_w_o    = exe_decode_i.is_store_op;
  assign dmem_addr_o = mem_addr[2 +: `DMEM_ADDR_WIDTH];
  assign dmem_data_o = store_data;
  assign dmem_mask_o = store_mask;

  assign local_load_v_o = local_op & ~exe_decode_i.is_store_op;
  assign reserve_o      = local_op &
                          (exe_decode_i.is_lr_op | exe_decode_i.is_lr_aq_op);

  // load info straight from decode with float_wb held low
  always_comb begin
    op_info.float_wb       = 1'b0;
    op_info.icache_fetch   = 1'b0;
    op_info.is_unsigned_op = exe_decode_i.is_load_unsigned;
    op_info.is_byte_op     = exe_decode_i.is_byte_op;
    op_info.is_hex_op      = exe_decode_i.is_hex_op;
    op_info.part_sel       = mem_addr[1:0];
  end

  // full word fetch for the icache
  always_comb begin
    fetch_info              = '0;
    fetch_info.icache_fetch = 1'b1;
  end

  assign load_info_o = op_info;

  always_comb begin
    if (icache_miss_i) begin
      remote_req_o.write_not_read = 1'b0;
      remote_req_o.is_amo_op      = 1'b0;
      remote_req_o.load_info      = fetch_info;
      remote_req_o.addr           = miss_addr;
    end else begin
      remote_req_o.write_not_read = exe_decode_i.is_store_op;
      remote_req_o.is_amo_op      = exe_decode_i.is_amo_op;
      remote_req_o.load_info      = op_info;
      remote_req_o.addr           = mem_addr;
    end
    remote_req_o.amo_type = exe_decode_i.amo_type;
    remote_req_o.mask     = store_mask;
    remote_req_o.reg_id   = exe_rd_i;
    remote_req_o.data     = store_data;
  end

  assign remote_v_o = icache_miss_i |
                      (~is_local & (exe_decode_i.is_load_op | exe_decode_i.is_store_op |
                                    exe_decode_i.is_amo_op));

  // atomics are only served by the remote side
  amo_not_local: assert property (
    @(posedge clk_i) disable iff (!reset_i)
    (exe_decode_i.is_amo_op && !icache_miss_i) |-> !is_local
  ) else $error("lsu: atomic operation on local dmem address 0x%08h", mem_addr);

  // reservations live in the local bank only
  lr_is_local: assert property (
    @(posedge clk_i) disable iff (!reset_i)
    ((exe_decode_i.is_lr_op || exe_decode_i.is_lr_aq_op) && !icache_miss_i) |-> is_local
  ) else $error("lsu: load reserved outside local dmem, addr 0x%08h", mem_addr);

endmodule

// File: source/mem_stage_pkg.sv
// memory stage types
// decode flags, load return info and the network request word

`include "mem_stage_defs.svh"

package mem_stage_pkg;

  // atomic kind carried to the remote side
  typedef enum logic [1:0] {
    AMO_SWAP = 2'b00,
    AMO_ADD  = 2'b01,
    AMO_AND  = 2'b10,
    AMO_OR   = 2'b11
  } amo_type_e;

  // operation flags from execute
  typedef struct packed {
    logic      is_load_op;
    logic      is_store_op;
    logic      is_byte_op;
    logic      is_hex_op;
    logic      is_load_unsigned;
    logic      is_amo_op;
    logic      is_lr_op;
    logic      is_lr_aq_op;
    logic      write_frd;
    amo_type_e amo_type;
  } decode_s;

  // how the returning word is handled
  typedef struct packed {
    logic       float_wb;
    logic       icache_fetch;
    logic       is_unsigned_op;
    logic       is_byte_op;
    logic       is_hex_op;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    logic                        write_not_read;
    logic                        is_amo_op;
    amo_type_e                   amo_type;
    logic [`DATA_MASK_WIDTH-1:0] mask;
    load_info_s                  load_info;
    logic [`REG_ADDR_WIDTH-1:0]  reg_id;
    logic [`DATA_WIDTH-1:0]      data;
    logic [`DATA_WIDTH-1:0]      addr;
  } remote_req_s;

endpackage

// File: source/mem_stage_defs.svh
// memory stage widths and address windows
// shared by the package and every RTL block of the stage

`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// datapath and address width
`define DATA_WIDTH 32
`define DATA_MASK_WIDTH (`DATA_WIDTH / 8)

// register file index
`define REG_ADDR_WIDTH 5

// local data memory, 1024 words
`define DMEM_ADDR_WIDTH 10

// local window spans 0x1000 through 0x1fff
`define DMEM_BASE 32'h0000_1000
`define DMEM_MASK 32'hffff_f000

// instruction fetches go to dram
`define DRAM_NPA_PREFIX 32'h8000_0000

// credits granted by the network at reset
`define TX_CREDITS 4

`endif
